// File: src/ex_pkg.sv
package ex_pkg;

	localparam int OPCODE_W  = 6;   // Opcode field of the decoded instruction
	localparam int REG_IDX_W = 5;   // 32 architectural registers

	// ALU operation codes
	typedef enum logic [OPCODE_W-1:0] {
		OP_ADD = 6'h00,
		OP_SUB = 6'h01,
		OP_AND = 6'h02,
		OP_OR  = 6'h03,
		OP_XOR = 6'h04,
		OP_SHL = 6'h05,   // Shift amount from low bits of operand 2
		OP_SHR = 6'h06,   // Logical, zero fill
		OP_MUL = 6'h07    // Iterative shift-add, low half of product
	} opcode_t;

	// Only the multiplier runs longer than one EX cycle
	localparam opcode_t MULTI_CYCLE_OP = OP_MUL;

	// True for opcodes that keep the EX stage busy over several cycles
	function automatic logic is_multi_cycle(opcode_t op);
		return op == MULTI_CYCLE_OP;
	endfunction

endpackage

// File: src/alu.sv
`timescale 1ns/10ps

module alu import ex_pkg::*; #(
	parameter int DATA_W = 32
) (
	input  logic              clk,
	input  logic              arst_n,
	input  logic              start,      // Valid operands from ID/EX
	input  opcode_t           opcode,
	input  logic [DATA_W-1:0] alu_in1,
	input  logic [DATA_W-1:0] alu_in2,
	output logic [DATA_W-1:0] alu_out,
	output logic              n,
	output logic              z,
	output logic              v,
	output logic              alu_done    // Result valid this cycle
);

	localparam int SH_W  = $clog2(DATA_W);
	localparam int CNT_W = $clog2(DATA_W + 1);

	logic [DATA_W-1:0] comb_out;
	logic [DATA_W-1:0] sum;
	logic [DATA_W-1:0] diff;
	logic [SH_W-1:0]   shamt;
	logic              is_mul;

	// Multiplier state
	logic              busy;
	logic [CNT_W-1:0]  step;     // Partial products accumulated so far
	logic [DATA_W-1:0] acc;
	logic [DATA_W-1:0] mcand;    // Multiplicand, shifted left each step
	logic [DATA_W-1:0] mplier;   // Multiplier, shifted right each step
	logic              mul_done;

	assign sum    = alu_in1 + alu_in2;
	assign diff   = alu_in1 - alu_in2;
	assign shamt  = alu_in2[SH_W-1:0];
	assign is_mul = is_multi_cycle(opcode);

	always_comb begin
		case (opcode)
			OP_ADD:  comb_out = sum;
			OP_SUB:  comb_out = diff;
			OP_AND:  comb_out = alu_in1 & alu_in2;
			OP_OR:   comb_out = alu_in1 | alu_in2;
			OP_XOR:  comb_out = alu_in1 ^ alu_in2;
			OP_SHL:  comb_out = alu_in1 << shamt;
			OP_SHR:  comb_out = alu_in1 >> shamt;
			default: comb_out = '0;   // MUL result comes from acc
		endcase
	end

	// Step counter, first partial product taken on the start edge
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			busy <= 1'b0;
			step <= '0;
		end else if (!busy) begin
			if (start && is_mul) begin
				busy <= 1'b1;
				step <= CNT_W'(1);
			end
		end else if (mul_done) begin
			busy <= 1'b0;   // Drops on the edge that hands off the result
		end else begin
			step <= step + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (!busy) begin
			acc    <= alu_in2[0] ? alu_in1 : '0;   // Bit 0 partial product
			mcand  <= alu_in1 << 1;
			mplier <= alu_in2 >> 1;
		end else if (!mul_done) begin
			if (mplier[0]) begin
				acc <= acc + mcand;
			end
			mcand  <= mcand << 1;
			mplier <= mplier >> 1;
		end
	end

	assign mul_done = busy && (step == CNT_W'(DATA_W));

	assign alu_out  = is_mul ? acc : comb_out;
	assign alu_done = is_mul ? mul_done : start;

	// Flags from the ALU result
	assign n = alu_out[DATA_W-1];
	assign z = (alu_out == '0);

	// Signed overflow, add and subtract only
	always_comb begin
		case (opcode)
			OP_ADD:  v = (alu_in1[DATA_W-1] == alu_in2[DATA_W-1]) &&
				     (sum[DATA_W-1] != alu_in1[DATA_W-1]);
			OP_SUB:  v = (alu_in1[DATA_W-1] != alu_in2[DATA_W-1]) &&
				     (diff[DATA_W-1] != alu_in1[DATA_W-1]);
			default: v = 1'b0;
		endcase
	end

	// ID/EX must hold the instruction for the whole multiply
	a_opcode_stable: assert property (@(posedge clk) disable iff (!arst_n)
		busy |-> $stable(opcode))
		else $error("opcode changed while the multiplier was busy");

endmodule

// File: src/ex_unit.sv
`timescale 1ns/10ps

module ex_unit import ex_pkg::*; #(
	parameter int DATA_W = 32
) (
	input  logic                 clk,
	input  logic                 arst_n,
	input  logic                 ex_valid,        // Instruction present in ID/EX
	input  opcode_t              opcode,
	input  logic                 reg_write_in, mem_write_in, mem_read_in,
	input  logic                 mem_to_reg_in, mem_src_in, branch_in,
	input  logic                 call_in, ret_in, pop_in,
	input  logic                 load_imm,        // Immediate instead of ALU result
	input  logic [REG_IDX_W-1:0] dest_reg_in,
	input  logic [DATA_W-1:0]    alu_input_1,
	input  logic [DATA_W-1:0]    alu_input_2,
	input  logic [DATA_W-1:0]    mem_write_data_in,
	input  logic [DATA_W-1:0]    pc_in,           // Stored on call
	output logic                 reg_write_out, mem_write_out, mem_read_out,
	output logic                 mem_to_reg_out, mem_src_out, branch_out,
	output logic                 call_out, ret_out, pop_out, load_imm_out,
	output logic [REG_IDX_W-1:0] dest_reg_out,
	output logic [DATA_W-1:0]    alu_addr,
	output logic [DATA_W-1:0]    non_alu_addr,
	output logic [DATA_W-1:0]    mem_write_data_out,
	output logic                 n_out, z_out, v_out,
	output logic                 alu_done,
	output logic                 stall
);

	logic [DATA_W-1:0] alu_out;

	alu #(
		.DATA_W   (DATA_W)
	) u_alu (
		.clk      (clk),
		.arst_n   (arst_n),
		.start    (ex_valid),
		.opcode   (opcode),
		.alu_in1  (alu_input_1),
		.alu_in2  (alu_input_2),
		.alu_out  (alu_out),
		.n        (n_out),
		.z        (z_out),
		.v        (v_out),
		.alu_done (alu_done)
	);

	// Address select, immediate load bypasses the ALU
	always_comb begin
		if (load_imm) begin
			alu_addr = alu_input_2;
		end else begin
			alu_addr = alu_out;
		end
	end

	// Store data select, call pushes the return PC
	always_comb begin
		if (call_in) begin
			mem_write_data_out = pc_in;
		end else begin
			mem_write_data_out = mem_write_data_in;
		end
	end

	assign non_alu_addr   = alu_input_1;   // Uncomputed address for pop and ret
	assign dest_reg_out   = dest_reg_in;   // SP override stays in decode

	// Straight through to EX/MEM
	assign reg_write_out  = reg_write_in;
	assign mem_write_out  = mem_write_in;
	assign mem_read_out   = mem_read_in;
	assign mem_to_reg_out = mem_to_reg_in;
	assign mem_src_out    = mem_src_in;
	assign branch_out     = branch_in;
	assign call_out       = call_in;
	assign ret_out        = ret_in;
	assign pop_out        = pop_in;
	assign load_imm_out   = load_imm;

	assign stall = ex_valid && !alu_done;   // Only the multiplier holds the stage

endmodule

// File: src/id_ex_reg.sv
`timescale 1ns/10ps

module id_ex_reg import ex_pkg::*; #(
	parameter int DATA_W = 32
) (
	input  logic                 clk,
	input  logic                 arst_n,
	input  logic                 issue,      // One-cycle strobe from decode
	input  logic                 stall,      // EX busy, hold contents
	input  opcode_t              opcode,
	input  logic                 reg_write_in, mem_write_in, mem_read_in,
	input  logic                 mem_to_reg_in, mem_src_in, branch_in,
	input  logic                 call_in, ret_in, pop_in, load_imm,
	input  logic [REG_IDX_W-1:0] dest_reg_in,
	input  logic [DATA_W-1:0]    alu_input_1,
	input  logic [DATA_W-1:0]    alu_input_2,
	input  logic [DATA_W-1:0]    mem_write_data_in,
	input  logic [DATA_W-1:0]    pc_in,
	output logic                 ex_valid,
	output opcode_t              ex_opcode,
	output logic                 ex_reg_write, ex_mem_write, ex_mem_read,
	output logic                 ex_mem_to_reg, ex_mem_src, ex_branch,
	output logic                 ex_call, ex_ret, ex_pop, ex_load_imm,
	output logic [REG_IDX_W-1:0] ex_dest_reg,
	output logic [DATA_W-1:0]    ex_alu_input_1,
	output logic [DATA_W-1:0]    ex_alu_input_2,
	output logic [DATA_W-1:0]    ex_mem_write_data,
	output logic [DATA_W-1:0]    ex_pc
);

	logic load;

	assign load = issue && !stall;   // Issue during stall is dropped

	// Valid bit and decoded controls
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			ex_valid      <= 1'b0;
			ex_opcode     <= OP_ADD;
			ex_reg_write  <= 1'b0;
			ex_mem_write  <= 1'b0;
			ex_mem_read   <= 1'b0;
			ex_mem_to_reg <= 1'b0;
			ex_mem_src    <= 1'b0;
			ex_branch     <= 1'b0;
			ex_call       <= 1'b0;
			ex_ret        <= 1'b0;
			ex_pop        <= 1'b0;
			ex_load_imm   <= 1'b0;
			ex_dest_reg   <= '0;
		end else if (load) begin
			ex_valid      <= 1'b1;
			ex_opcode     <= opcode;
			ex_reg_write  <= reg_write_in;
			ex_mem_write  <= mem_write_in;
			ex_mem_read   <= mem_read_in;
			ex_mem_to_reg <= mem_to_reg_in;
			ex_mem_src    <= mem_src_in;
			ex_branch     <= branch_in;
			ex_call       <= call_in;
			ex_ret        <= ret_in;
			ex_pop        <= pop_in;
			ex_load_imm   <= load_imm;
			ex_dest_reg   <= dest_reg_in;
		end else if (!stall) begin
			ex_valid      <= 1'b0;   // Bubble
		end
	end

	// Operands and PC
	always_ff @(posedge clk) begin
		if (load) begin
			ex_alu_input_1    <= alu_input_1;
			ex_alu_input_2    <= alu_input_2;
			ex_mem_write_data <= mem_write_data_in;
			ex_pc             <= pc_in;
		end
	end

	a_no_issue_in_stall: assert property (@(posedge clk) disable iff (!arst_n)
		!(issue && stall))
		else $error("issue raised while the EX stage was stalled");

endmodule

// File: src/ex_mem_reg.sv
`timescale 1ns/10ps

module ex_mem_reg import ex_pkg::*; #(
	parameter int DATA_W = 32
) (
	input  logic                 clk,
	input  logic                 arst_n,
	input  logic                 alu_done,   // EX result ready
	input  logic                 reg_write_d, mem_write_d, mem_read_d,
	input  logic                 mem_to_reg_d, mem_src_d, branch_d,
	input  logic                 call_d, ret_d, pop_d, load_imm_d,
	input  logic [REG_IDX_W-1:0] dest_reg_d,
	input  logic [DATA_W-1:0]    alu_addr_d,
	input  logic [DATA_W-1:0]    non_alu_addr_d,
	input  logic [DATA_W-1:0]    mem_write_data_d,
	input  logic                 n_d, z_d, v_d,
	output logic                 mem_valid,  // One pulse per instruction
	output logic                 reg_write_out, mem_write_out, mem_read_out,
	output logic                 mem_to_reg_out, mem_src_out, branch_out,
	output logic                 call_out, ret_out, pop_out, load_imm_out,
	output logic [REG_IDX_W-1:0] dest_reg_out,
	output logic [DATA_W-1:0]    alu_addr,
	output logic [DATA_W-1:0]    non_alu_addr,
	output logic [DATA_W-1:0]    mem_write_data_out,
	output logic                 n_out, z_out, v_out
);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			mem_valid          <= 1'b0;
			reg_write_out      <= 1'b0;
			mem_write_out      <= 1'b0;
			mem_read_out       <= 1'b0;
			mem_to_reg_out     <= 1'b0;
			mem_src_out        <= 1'b0;
			branch_out         <= 1'b0;
			call_out           <= 1'b0;
			ret_out            <= 1'b0;
			pop_out            <= 1'b0;
			load_imm_out       <= 1'b0;
			dest_reg_out       <= '0;
			alu_addr           <= '0;
			non_alu_addr       <= '0;
			mem_write_data_out <= '0;
			n_out              <= 1'b0;
			z_out              <= 1'b0;
			v_out              <= 1'b0;
		end else begin
			mem_valid <= alu_done;   // High for the cycle after done
			if (alu_done) begin
				reg_write_out      <= reg_write_d;
				mem_write_out      <= mem_write_d;
				mem_read_out       <= mem_read_d;
				mem_to_reg_out     <= mem_to_reg_d;
				mem_src_out        <= mem_src_d;
				branch_out         <= branch_d;
				call_out           <= call_d;
				ret_out            <= ret_d;
				pop_out            <= pop_d;
				load_imm_out       <= load_imm_d;
				dest_reg_out       <= dest_reg_d;
				alu_addr           <= alu_addr_d;
				non_alu_addr       <= non_alu_addr_d;
				mem_write_data_out <= mem_write_data_d;
				n_out              <= n_d;
				z_out              <= z_d;
				v_out              <= v_d;
			end
		end
	end

	// A completed instruction carries only known result bits
	a_result_known: assert property (@(posedge clk) disable iff (!arst_n)
		alu_done |-> !$isunknown({dest_reg_d, alu_addr_d, non_alu_addr_d,
			mem_write_data_d, n_d, z_d, v_d}))
		else $error("EX result captured with unknown bits");

endmodule

// File: src/ex_stage_top.sv
`timescale 1ns/10ps

module ex_stage_top import ex_pkg::*; #(
	parameter int DATA_W = 32
) (
	input  logic                 clk,
	input  logic                 arst_n,
	input  logic                 issue,
	input  opcode_t              opcode,
	input  logic                 reg_write_in, mem_write_in, mem_read_in,
	input  logic                 mem_to_reg_in, mem_src_in, branch_in,
	input  logic                 call_in, ret_in, pop_in, load_imm,
	input  logic [REG_IDX_W-1:0] dest_reg_in,
	input  logic [DATA_W-1:0]    alu_input_1,
	input  logic [DATA_W-1:0]    alu_input_2,
	input  logic [DATA_W-1:0]    mem_write_data_in,
	input  logic [DATA_W-1:0]    pc_in,
	output logic                 stall,
	output logic                 mem_valid,
	output logic                 reg_write_out, mem_write_out, mem_read_out,
	output logic                 mem_to_reg_out, mem_src_out, branch_out,
	output logic                 call_out, ret_out, pop_out, load_imm_out,
	output logic [REG_IDX_W-1:0] dest_reg_out,
	output logic [DATA_W-1:0]    alu_addr,
	output logic [DATA_W-1:0]    non_alu_addr,
	output logic [DATA_W-1:0]    mem_write_data_out,
	output logic                 n_out, z_out, v_out
);

	// ID/EX to EX unit
	logic                 ex_valid;
	opcode_t              ex_opcode;
	logic                 ex_reg_write, ex_mem_write, ex_mem_read, ex_mem_to_reg;
	logic                 ex_mem_src, ex_branch, ex_call, ex_ret, ex_pop, ex_load_imm;
	logic [REG_IDX_W-1:0] ex_dest_reg;
	logic [DATA_W-1:0]    ex_alu_input_1, ex_alu_input_2, ex_mem_write_data, ex_pc;

	// EX unit to EX/MEM
	logic                 alu_done;
	logic                 reg_write_d, mem_write_d, mem_read_d, mem_to_reg_d;
	logic                 mem_src_d, branch_d, call_d, ret_d, pop_d, load_imm_d;
	logic [REG_IDX_W-1:0] dest_reg_d;
	logic [DATA_W-1:0]    alu_addr_d, non_alu_addr_d, mem_write_data_d;
	logic                 n_d, z_d, v_d;

	id_ex_reg #(.DATA_W(DATA_W)) u_id_ex_reg (
		.clk, .arst_n, .issue, .stall, .opcode,
		.reg_write_in, .mem_write_in, .mem_read_in, .mem_to_reg_in, .mem_src_in,
		.branch_in, .call_in, .ret_in, .pop_in, .load_imm, .dest_reg_in,
		.alu_input_1, .alu_input_2, .mem_write_data_in, .pc_in,
		.ex_valid, .ex_opcode,
		.ex_reg_write, .ex_mem_write, .ex_mem_read, .ex_mem_to_reg, .ex_mem_src,
		.ex_branch, .ex_call, .ex_ret, .ex_pop, .ex_load_imm, .ex_dest_reg,
		.ex_alu_input_1, .ex_alu_input_2, .ex_mem_write_data, .ex_pc
	);

	ex_unit #(.DATA_W(DATA_W)) u_ex_unit (
		.clk, .arst_n, .ex_valid,
		.opcode             (ex_opcode),
		.reg_write_in       (ex_reg_write),
		.mem_write_in       (ex_mem_write),
		.mem_read_in        (ex_mem_read),
		.mem_to_reg_in      (ex_mem_to_reg),
		.mem_src_in         (ex_mem_src),
		.branch_in          (ex_branch),
		.call_in            (ex_call),
		.ret_in             (ex_ret),
		.pop_in             (ex_pop),
		.load_imm           (ex_load_imm),
		.dest_reg_in        (ex_dest_reg),
		.alu_input_1        (ex_alu_input_1),
		.alu_input_2        (ex_alu_input_2),
		.mem_write_data_in  (ex_mem_write_data),
		.pc_in              (ex_pc),
		.reg_write_out      (reg_write_d),
		.mem_write_out      (mem_write_d),
		.mem_read_out       (mem_read_d),
		.mem_to_reg_out     (mem_to_reg_d),
		.mem_src_out        (mem_src_d),
		.branch_out         (branch_d),
		.call_out           (call_d),
		.ret_out            (ret_d),
		.pop_out            (pop_d),
		.load_imm_out       (load_imm_d),
		.dest_reg_out       (dest_reg_d),
		.alu_addr           (alu_addr_d),
		.non_alu_addr       (non_alu_addr_d),
		.mem_write_data_out (mem_write_data_d),
		.n_out              (n_d),
		.z_out              (z_d),
		.v_out              (v_d),
		.alu_done, .stall
	);

	ex_mem_reg #(.DATA_W(DATA_W)) u_ex_mem_reg (
		.clk, .arst_n, .alu_done,
		.reg_write_d, .mem_write_d, .mem_read_d, .mem_to_reg_d, .mem_src_d,
		.branch_d, .call_d, .ret_d, .pop_d, .load_imm_d, .dest_reg_d,
		.alu_addr_d, .non_alu_addr_d, .mem_write_data_d, .n_d, .z_d, .v_d,
		.mem_valid,
		.reg_write_out, .mem_write_out, .mem_read_out, .mem_to_reg_out, .mem_src_out,
		.branch_out, .call_out, .ret_out, .pop_out, .load_imm_out, .dest_reg_out,
		.alu_addr, .non_alu_addr, .mem_write_data_out, .n_out, .z_out, .v_out
	);

endmodule

// File: dv/ex_stage_checker.sv
`timescale 1ns/10ps

module ex_stage_checker import ex_pkg::*; #(
	parameter int DATA_W = 32
) (
	input  logic                 clk,
	input  logic                 arst_n,
	input  logic [8*12-1:0]      test_name,    // Row currently on the inputs
	input  logic                 issue,
	input  opcode_t              opcode,
	input  logic                 reg_write_in, mem_write_in, mem_read_in,
	input  logic                 mem_to_reg_in, mem_src_in, branch_in,
	input  logic                 call_in, ret_in, pop_in, load_imm,
	input  logic [REG_IDX_W-1:0] dest_reg_in,
	input  logic [DATA_W-1:0]    alu_input_1, alu_input_2,
	input  logic [DATA_W-1:0]    mem_write_data_in, pc_in,
	input  logic                 stall, mem_valid,
	input  logic                 reg_write_out, mem_write_out, mem_read_out,
	input  logic                 mem_to_reg_out, mem_src_out, branch_out,
	input  logic                 call_out, ret_out, pop_out, load_imm_out,
	input  logic [REG_IDX_W-1:0] dest_reg_out,
	input  logic [DATA_W-1:0]    alu_addr, non_alu_addr, mem_write_data_out,
	input  logic                 n_out, z_out, v_out,
	output int                   mismatch_count,
	output int                   fault_count,
	output int                   pending       // Instructions still in flight
);

	localparam int SH_W = $clog2(DATA_W);

	// One expected EX/MEM result
	typedef struct packed {
		logic [8*12-1:0]      name;
		logic [9:0]           ctrl;   // Same order as the port list
		logic [REG_IDX_W-1:0] dest;
		logic [DATA_W-1:0]    addr, non_addr, wdata;
		logic [2:0]           nzv;
		int                   due;    // Cycle of the mem_valid pulse
	} expect_t;

	expect_t         exp_q[$];
	expect_t         head;
	int              cycle;
	int              busy_from;      // Cycles where the multiplier holds the stage
	int              busy_to;
	logic [8*12-1:0] busy_name;
	logic            started;
	logic            exp_stall;

	// Result model from the ALU rules
	function automatic expect_t predict(input int now);
		expect_t             e;
		logic [DATA_W-1:0]   res;
		logic [DATA_W:0]     wide;   // Sign-extended sum or difference
		logic [2*DATA_W-1:0] prod;
		logic                ovf;
		ovf  = 1'b0;
		wide = '0;
		prod = {{DATA_W{1'b0}}, alu_input_1} * {{DATA_W{1'b0}}, alu_input_2};
		case (opcode)
			OP_ADD: begin
				wide = {alu_input_1[DATA_W-1], alu_input_1} +
				       {alu_input_2[DATA_W-1], alu_input_2};
				res  = wide[DATA_W-1:0];
				ovf  = wide[DATA_W] ^ wide[DATA_W-1];   // Result does not fit
			end
			OP_SUB: begin
				wide = {alu_input_1[DATA_W-1], alu_input_1} -
				       {alu_input_2[DATA_W-1], alu_input_2};
				res  = wide[DATA_W-1:0];
				ovf  = wide[DATA_W] ^ wide[DATA_W-1];
			end
			OP_AND:  res = alu_input_1 & alu_input_2;
			OP_OR:   res = alu_input_1 | alu_input_2;
			OP_XOR:  res = alu_input_1 ^ alu_input_2;
			OP_SHL:  res = alu_input_1 << alu_input_2[SH_W-1:0];
			OP_SHR:  res = alu_input_1 >> alu_input_2[SH_W-1:0];
			OP_MUL:  res = prod[DATA_W-1:0];   // Low half only
			default: res = '0;
		endcase
		e.name     = test_name;
		e.ctrl     = {reg_write_in, mem_write_in, mem_read_in, mem_to_reg_in, mem_src_in,
		              branch_in, call_in, ret_in, pop_in, load_imm};
		e.dest     = dest_reg_in;
		e.addr     = load_imm ? alu_input_2 : res;
		e.non_addr = alu_input_1;
		e.wdata    = call_in ? pc_in : mem_write_data_in;
		e.nzv      = {res[DATA_W-1], res == '0, ovf};   // Flags follow the ALU, not the mux
		e.due      = now + ((opcode == OP_MUL) ? DATA_W + 2 : 2);
		return e;
	endfunction

	function automatic logic outputs_set();
		return |{reg_write_out, mem_write_out, mem_read_out, mem_to_reg_out, mem_src_out,
		         branch_out, call_out, ret_out, pop_out, load_imm_out, dest_reg_out,
		         alu_addr, non_alu_addr, mem_write_data_out, n_out, z_out, v_out};
	endfunction

	task automatic compare(input logic [8*12-1:0] name, input string field,
		input logic [63:0] exp_val, input logic [63:0] act_val);
		if (exp_val !== act_val) begin
			mismatch_count++;
			$display("Mismatch %0s %0s expected %0h actual %0h", name, field, exp_val, act_val);
		end
	endtask

	task automatic check_result(input expect_t e);
		if (cycle != e.due) begin
			mismatch_count++;
			$display("Mismatch %0s cycle expected %0d actual %0d", e.name, e.due, cycle);
		end
		compare(e.name, "controls", 64'(e.ctrl), 64'({reg_write_out, mem_write_out,
			mem_read_out, mem_to_reg_out, mem_src_out, branch_out, call_out, ret_out,
			pop_out, load_imm_out}));
		compare(e.name, "dest_reg", 64'(e.dest), 64'(dest_reg_out));
		compare(e.name, "alu_addr", 64'(e.addr), 64'(alu_addr));
		compare(e.name, "non_alu_addr", 64'(e.non_addr), 64'(non_alu_addr));
		compare(e.name, "store_data", 64'(e.wdata), 64'(mem_write_data_out));
		compare(e.name, "nzv", 64'(e.nzv), 64'({n_out, z_out, v_out}));
	endtask

	// Everything sampled mid-cycle, inputs and outputs both settled
	always @(negedge clk) begin
		if (!arst_n) begin
			cycle          = 0;
			busy_from      = 1;
			busy_to        = 0;   // Empty window
			busy_name      = '0;
			started        = 1'b0;
			mismatch_count = 0;
			fault_count    = 0;
			exp_q.delete();
		end else begin
			cycle++;
			exp_stall = (cycle >= busy_from) && (cycle <= busy_to);
			if (stall !== exp_stall) begin
				mismatch_count++;
				$display("Mismatch %0s stall expected %b actual %b", busy_name, exp_stall, stall);
			end
			if (!started && (mem_valid || stall || outputs_set())) begin
				fault_count++;
				$display("Outputs were not all zero after reset and before the first issue");
			end
			if (mem_valid) begin
				if (exp_q.size() == 0) begin
					fault_count++;
					$display("mem_valid pulsed in cycle %0d with nothing in flight", cycle);
				end else begin
					head = exp_q.pop_front();
					check_result(head);
				end
			end
			if (issue && !stall) begin   // Accepted this cycle
				started = 1'b1;
				exp_q.push_back(predict(cycle));
				if (opcode == OP_MUL) begin
					busy_from = cycle + 1;
					busy_to   = cycle + DATA_W;
					busy_name = test_name;
				end
			end
		end
		pending = exp_q.size();
	end

endmodule

// File: dv/ex_stage_tb.sv
`timescale 1ns/10ps

module ex_stage_tb import ex_pkg::*; #(
	parameter int DATA_W = 32
);

	// Stimulus row
	typedef struct packed {
		logic [8*12-1:0]      name;
		opcode_t              op;
		logic [9:0]           ctrl;   // reg_write first, load_imm last
		logic [REG_IDX_W-1:0] dest;
		logic [DATA_W-1:0]    a, b, wdata, pc;
	} row_t;

	localparam int NUM_FIXED   = 17;
	localparam int NUM_RAND    = 8;
	localparam int NUM_ROWS    = NUM_FIXED + NUM_RAND;
	localparam int CYCLE_LIMIT = NUM_ROWS * (DATA_W + 4) + 40;
	localparam logic [DATA_W-1:0] MAX_POS = {1'b0, {(DATA_W-1){1'b1}}};
	localparam logic [DATA_W-1:0] MIN_NEG = {1'b1, {(DATA_W-1){1'b0}}};

	// Control bits
	localparam logic [9:0] C_RW   = 10'h200;
	localparam logic [9:0] C_MW   = 10'h100;
	localparam logic [9:0] C_MR   = 10'h080;
	localparam logic [9:0] C_M2R  = 10'h040;
	localparam logic [9:0] C_MSRC = 10'h020;
	localparam logic [9:0] C_BR   = 10'h010;
	localparam logic [9:0] C_CALL = 10'h008;
	localparam logic [9:0] C_RET  = 10'h004;
	localparam logic [9:0] C_POP  = 10'h002;
	localparam logic [9:0] C_LIMM = 10'h001;

	logic                 clk, arst_n, issue;
	opcode_t              opcode;
	logic                 reg_write_in, mem_write_in, mem_read_in, mem_to_reg_in, mem_src_in;
	logic                 branch_in, call_in, ret_in, pop_in, load_imm;
	logic [REG_IDX_W-1:0] dest_reg_in, dest_reg_out;
	logic [DATA_W-1:0]    alu_input_1, alu_input_2, mem_write_data_in, pc_in;
	logic                 stall, mem_valid;
	logic                 reg_write_out, mem_write_out, mem_read_out, mem_to_reg_out;
	logic                 mem_src_out, branch_out, call_out, ret_out, pop_out, load_imm_out;
	logic [DATA_W-1:0]    alu_addr, non_alu_addr, mem_write_data_out;
	logic                 n_out, z_out, v_out;
	logic [8*12-1:0]      test_name;
	int                   mismatch_count, fault_count, pending;

	row_t rows [NUM_ROWS];
	int   seed;
	int   cycle_count;

	ex_stage_top #(.DATA_W(DATA_W)) u_ex_stage_top (.*);

	ex_stage_checker #(.DATA_W(DATA_W)) u_ex_stage_checker (.*);

	initial clk = 1'b0;
	always #20 clk = ~clk;   // 40 ns period

	// Hang guard, sized from the row count
	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= CYCLE_LIMIT) begin
			$display("Run hung: %0d instructions still in flight after %0d cycles",
				pending, CYCLE_LIMIT);
			$display("Errors: %0d mismatches, %0d other failures", mismatch_count, fault_count);
			$display("TESTS FAILED");
			$finish;
		end
	end

	task automatic set_row(input int idx, input logic [8*12-1:0] name, input opcode_t op,
		input logic [9:0] ctrl, input logic [DATA_W-1:0] a, input logic [DATA_W-1:0] b);
		rows[idx].name  = name;
		rows[idx].op    = op;
		rows[idx].ctrl  = ctrl;
		rows[idx].dest  = REG_IDX_W'(idx + 1);
		rows[idx].a     = a;
		rows[idx].b     = b;
		rows[idx].wdata = DATA_W'(32'hc0de_0000 + idx);   // Distinct per row
		rows[idx].pc    = DATA_W'(32'h1000 + 4 * idx);
	endtask

	task automatic fill_rows();
		set_row(0,  "add_basic",  OP_ADD, C_RW, 5, 7);
		set_row(1,  "add_ovf",    OP_ADD, C_RW, MAX_POS, 1);      // V on add
		set_row(2,  "sub_basic",  OP_SUB, C_RW, 20, 8);
		set_row(3,  "sub_ovf",    OP_SUB, C_RW, MIN_NEG, 1);      // V on subtract
		set_row(4,  "sub_zero",   OP_SUB, C_RW | C_BR, 9, 9);     // Z
		set_row(5,  "and_op",     OP_AND, C_RW, 'hf0f0, 'hff00);
		set_row(6,  "or_op",      OP_OR,  C_RW, 'h0f0f, 'h3030);
		set_row(7,  "xor_neg",    OP_XOR, C_RW, MIN_NEG | 1, 3);  // N
		set_row(8,  "shl_op",     OP_SHL, C_RW, 1, 4);
		set_row(9,  "shr_op",     OP_SHR, C_RW, MIN_NEG, 3);
		set_row(10, "load_imm",   OP_ADD, C_RW | C_MR | C_M2R | C_LIMM, 'h40, 'h1234);
		set_row(11, "call_store", OP_SUB, C_MW | C_MSRC | C_CALL, 'h80, 4);
		set_row(12, "pop_ret",    OP_ADD, C_MR | C_RET | C_POP, 'h200, 4);
		set_row(13, "mul_small",  OP_MUL, C_RW, 6, 7);
		set_row(14, "mul_neg",    OP_MUL, C_RW, DATA_W'(-3), 5);
		set_row(15, "b2b_add",    OP_ADD, C_RW, 100, 23);
		set_row(16, "b2b_xor",    OP_XOR, C_RW, 'haaaa, 'h5555);
		// Random operands and controls, every opcode once
		for (int k = 0; k < NUM_RAND; k++) begin
			set_row(NUM_FIXED + k, {"rand_", 8'(8'h30 + k)}, opcode_t'(k),
				10'($random(seed)), DATA_W'({$random(seed), $random(seed)}),
				DATA_W'({$random(seed), $random(seed)}));
		end
	endtask

	task automatic apply_row(input row_t r);
		test_name <= r.name;
		opcode    <= r.op;
		{reg_write_in, mem_write_in, mem_read_in, mem_to_reg_in, mem_src_in,
		 branch_in, call_in, ret_in, pop_in, load_imm} <= r.ctrl;
		dest_reg_in       <= r.dest;
		alu_input_1       <= r.a;
		alu_input_2       <= r.b;
		mem_write_data_in <= r.wdata;
		pc_in             <= r.pc;
		issue             <= 1'b1;
	endtask

	initial begin
		seed        = 32'h7080d757;
		cycle_count = 0;
		arst_n      = 1'b0;
		issue       = 1'b0;
		opcode      = OP_ADD;
		{reg_write_in, mem_write_in, mem_read_in, mem_to_reg_in, mem_src_in,
		 branch_in, call_in, ret_in, pop_in, load_imm} = '0;
		dest_reg_in       = '0;
		alu_input_1       = '0;
		alu_input_2       = '0;
		mem_write_data_in = '0;
		pc_in             = '0;
		test_name         = '0;
		fill_rows();
		repeat (5) @(posedge clk);
		arst_n <= 1'b1;
		repeat (3) @(posedge clk);   // Idle window, outputs must stay zero
		for (int i = 0; i < NUM_ROWS; i++) begin
			@(negedge clk);
			while (stall) @(negedge clk);   // Multiplier still busy
			@(posedge clk);
			apply_row(rows[i]);
			if (rows[i].op == OP_MUL) begin
				@(posedge clk);
				issue <= 1'b0;   // Stall rises next cycle, so drop issue
			end
		end
		@(posedge clk);
		issue <= 1'b0;
		while (pending != 0) @(posedge clk);
		repeat (3) @(posedge clk);   // Catch any stray mem_valid
		$display("Errors: %0d mismatches, %0d other failures", mismatch_count, fault_count);
		if (mismatch_count == 0 && fault_count == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

endmodule

// File: filelist.f
src/ex_pkg.sv
src/alu.sv
src/ex_unit.sv
src/id_ex_reg.sv
src/ex_mem_reg.sv
src/ex_stage_top.sv
dv/ex_stage_checker.sv
dv/ex_stage_tb.sv

// File: Makefile
# Verilator build and run for the EX stage testbench

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -Wno-fatal --top-module ex_stage_tb \
		-f filelist.f -Mdir obj_dir -o ex_stage_sim

run: compile
	@out="$$(./obj_dir/ex_stage_sim)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TESTS PASSED"

clean:
	rm -rf obj_dir
